//--- rtl/frogger_pkg.sv
package frogger_pkg;

    // Playfield grid dimensions
    localparam int GRID_COLS = 14;
    localparam int GRID_ROWS = 15;

    // Width of a column or row index
    localparam int POS_W = 6;

    // Frog respawn cell, bottom row
    localparam int SPAWN_X = 10;
    localparam int SPAWN_Y = 14;

    // Tile code of a single grid cell
    typedef enum logic [3:0] {
        TILE_SAFE      = 4'd0,
        TILE_WATER     = 4'd1,
        TILE_LOG       = 4'd2,
        TILE_ROAD      = 4'd3,
        TILE_CAR       = 4'd4,
        TILE_LILY      = 4'd5,
        TILE_GOAL_BANK = 4'd6
    } tile_t;

    // Configuration register map
    localparam logic [1:0] REG_LOG_PERIOD = 2'd0;
    localparam logic [1:0] REG_CAR_PERIOD = 2'd1;
    // Bit 0 scroll enable, bit 1 restart
    localparam logic [1:0] REG_CTRL       = 2'd2;

    // Scroll period width in clock cycles
    localparam int PERIOD_W = 16;

endpackage

//--- rtl/game_cfg_regs.sv
`timescale 1ns/10ps

module game_cfg_regs (
    input  logic                             i_Clk,
    input  logic                             i_rst_n,
    input  logic                             i_Cfg_Wr,
    input  logic [1:0]                       i_Cfg_Addr,
    input  logic [frogger_pkg::PERIOD_W-1:0] i_Cfg_Data,
    output logic [frogger_pkg::PERIOD_W-1:0] o_Log_Period,
    output logic [frogger_pkg::PERIOD_W-1:0] o_Car_Period,
    output logic                             o_Scroll_En,
    output logic                             o_Restart
);

    import frogger_pkg::*;

    // Default scroll period after reset
    localparam logic [PERIOD_W-1:0] RESET_PERIOD = PERIOD_W'(1000);

    logic [PERIOD_W-1:0] r_log_period;
    logic [PERIOD_W-1:0] r_car_period;
    logic                r_scroll_en;
    logic                r_restart;
    logic [PERIOD_W-1:0] w_period_in;

    // Zero period would never wrap, store as 1
    assign w_period_in = (i_Cfg_Data == '0) ? PERIOD_W'(1) : i_Cfg_Data;

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_log_period <= RESET_PERIOD;
            r_car_period <= RESET_PERIOD;
            r_scroll_en  <= 1'b0;
            r_restart    <= 1'b0;
        end else begin
            // Restart lasts one cycle only
            r_restart <= 1'b0;
            if (i_Cfg_Wr) begin
                case (i_Cfg_Addr)
                    REG_LOG_PERIOD: r_log_period <= w_period_in;
                    REG_CAR_PERIOD: r_car_period <= w_period_in;
                    REG_CTRL: begin
                        r_scroll_en <= i_Cfg_Data[0];
                        // Restart bit is a strobe, never stored
                        r_restart   <= i_Cfg_Data[1];
                    end
                    // Address 3 unmapped
                    default: begin
                    end
                endcase
            end
        end
    end

    assign o_Log_Period = r_log_period;
    assign o_Car_Period = r_car_period;
    assign o_Scroll_En  = r_scroll_en;
    assign o_Restart    = r_restart;

endmodule

//--- rtl/playfield_map.sv
`timescale 1ns/10ps

module playfield_map #(
    parameter int LOG_LEN = 5,
    parameter int CAR_LEN = 2
) (
    input  logic                             i_Clk,
    input  logic                             i_rst_n,
    input  logic [frogger_pkg::PERIOD_W-1:0] i_Log_Period,
    input  logic [frogger_pkg::PERIOD_W-1:0] i_Car_Period,
    input  logic                             i_Scroll_En,
    input  logic                             i_Restart,
    input  logic [frogger_pkg::POS_W-1:0]    i_Frog_X,
    input  logic [frogger_pkg::POS_W-1:0]    i_Frog_Y,
    output frogger_pkg::tile_t               o_Tile,
    output logic                             o_On_Log,
    output logic                             o_Hazard,
    output logic                             o_Log_Tick
);

    import frogger_pkg::*;

    // Lane indices
    localparam int LANE_LOG = 0;
    localparam int LANE_CAR = 1;

    // Offsets run 0..13
    localparam logic [3:0] OFF_LAST = 4'(GRID_COLS - 1);

    // Row bands
    localparam logic [POS_W-1:0] WATER_FIRST = POS_W'(1);
    localparam logic [POS_W-1:0] WATER_LAST  = POS_W'(6);
    localparam logic [POS_W-1:0] ROAD_FIRST  = POS_W'(8);
    localparam logic [POS_W-1:0] ROAD_LAST   = POS_W'(13);
    localparam logic [POS_W-1:0] COLS        = POS_W'(GRID_COLS);

    logic [1:0][PERIOD_W-1:0] w_period;
    logic [1:0][3:0]          w_off;
    logic [1:0]               w_wrap;

    logic [POS_W-1:0] w_log_sum;
    logic [POS_W-1:0] w_log_pos;
    logic [POS_W-1:0] w_car_off;
    logic [POS_W-1:0] w_car_pos;
    logic             w_log_here;
    logic             w_car_here;
    logic             w_lily_col;

    assign w_period[LANE_LOG] = i_Log_Period;
    assign w_period[LANE_CAR] = i_Car_Period;

    // One cycle counter and offset per lane
    for (genvar g = 0; g < 2; g++) begin : g_lane
        logic [PERIOD_W-1:0] r_cnt;
        logic [3:0]          r_off;

        // Wrap at period minus one, also catches a period shrunk below the count
        assign w_wrap[g] = i_Scroll_En && !i_Restart && (r_cnt >= w_period[g] - 1'b1);
        assign w_off[g]  = r_off;

        always_ff @(posedge i_Clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                r_cnt <= '0;
                r_off <= '0;
            end else if (i_Restart) begin
                r_cnt <= '0;
                r_off <= '0;
            end else if (i_Scroll_En) begin
                if (w_wrap[g]) begin
                    r_cnt <= '0;
                    // Offset steps once per period, modulo grid width
                    r_off <= (r_off == OFF_LAST) ? 4'd0 : r_off + 1'b1;
                end else begin
                    r_cnt <= r_cnt + 1'b1;
                end
            end
        end
    end

    // Tick lands on the same edge as the log offset step
    assign o_Log_Tick = w_wrap[LANE_LOG];

    // Logs: (col + offset) mod 14, moving left
    assign w_log_sum  = i_Frog_X + POS_W'(w_off[LANE_LOG]);
    assign w_log_pos  = (w_log_sum >= COLS) ? w_log_sum - COLS : w_log_sum;
    assign w_log_here = (w_log_pos < POS_W'(LOG_LEN));

    // Cars: (col - offset) mod 14, moving right
    assign w_car_off  = POS_W'(w_off[LANE_CAR]);
    assign w_car_pos  = (i_Frog_X >= w_car_off) ? i_Frog_X - w_car_off
                                                : i_Frog_X + COLS - w_car_off;
    assign w_car_here = (w_car_pos < POS_W'(CAR_LEN));

    // Lily pads fixed every third column from 1
    assign w_lily_col = i_Frog_X inside {POS_W'(1), POS_W'(4), POS_W'(7), POS_W'(10),
                                         POS_W'(13)};

    // Tile of the frog's cell by row band
    always_comb begin
        if (i_Frog_Y == '0) begin
            o_Tile = w_lily_col ? TILE_LILY : TILE_GOAL_BANK;
        end else if (i_Frog_Y >= WATER_FIRST && i_Frog_Y <= WATER_LAST) begin
            o_Tile = w_log_here ? TILE_LOG : TILE_WATER;
        end else if (i_Frog_Y >= ROAD_FIRST && i_Frog_Y <= ROAD_LAST) begin
            o_Tile = w_car_here ? TILE_CAR : TILE_ROAD;
        end else begin
            // Verge row 7 and start row 14
            o_Tile = TILE_SAFE;
        end
    end

    assign o_On_Log = (o_Tile == TILE_LOG);
    // Open water or a car kills the frog
    assign o_Hazard = (o_Tile == TILE_WATER) || (o_Tile == TILE_CAR);

endmodule

//--- rtl/frog_ctrl.sv
`timescale 1ns/10ps

module frog_ctrl #(
    parameter int START_LIVES = 3
) (
    input  logic                          i_Clk,
    input  logic                          i_rst_n,
    input  logic                          i_Up_Mvt,
    input  logic                          i_Down_Mvt,
    input  logic                          i_Left_Mvt,
    input  logic                          i_Right_Mvt,
    input  frogger_pkg::tile_t            i_Tile,
    input  logic                          i_On_Log,
    input  logic                          i_Hazard,
    input  logic                          i_Log_Tick,
    input  logic                          i_Restart,
    output logic [frogger_pkg::POS_W-1:0] o_Frog_X,
    output logic [frogger_pkg::POS_W-1:0] o_Frog_Y,
    output logic [6:0]                    o_Score,
    output logic [1:0]                    o_Lives,
    output logic                          o_Game_Over
);

    import frogger_pkg::*;

    localparam logic [POS_W-1:0] X_LAST     = POS_W'(GRID_COLS - 1);
    localparam logic [POS_W-1:0] Y_LAST     = POS_W'(GRID_ROWS - 1);
    localparam logic [POS_W-1:0] X_SPAWN    = POS_W'(SPAWN_X);
    localparam logic [POS_W-1:0] Y_SPAWN    = POS_W'(SPAWN_Y);
    localparam logic [1:0]       LIVES_FULL = 2'(START_LIVES);

    // Button order: up, down, left, right
    logic [3:0]       w_btn;
    logic [3:0]       r_btn_prev;
    logic [3:0]       w_press;
    logic [POS_W-1:0] r_frog_x;
    logic [POS_W-1:0] r_frog_y;
    logic [POS_W-1:0] w_drift_x;
    logic [POS_W-1:0] w_next_x;
    logic [POS_W-1:0] w_next_y;
    logic [6:0]       r_score;
    logic [1:0]       r_lives;
    logic             w_game_over;
    logic             w_at_goal;

    assign w_btn       = {i_Up_Mvt, i_Down_Mvt, i_Left_Mvt, i_Right_Mvt};
    // Rising edge against last sample
    assign w_press     = w_btn & ~r_btn_prev;
    assign w_game_over = (r_lives == '0);
    assign w_at_goal   = (r_frog_y == '0);

    always_comb begin
        // Log carries frog one column left, wrapping at the edge
        w_drift_x = r_frog_x;
        if (i_Log_Tick && i_On_Log) begin
            w_drift_x = (r_frog_x == '0) ? X_LAST : r_frog_x - 1'b1;
        end
        w_next_x = w_drift_x;
        w_next_y = r_frog_y;
        // One move per edge, up wins over down over left over right
        if (w_press[3]) begin
            if (r_frog_y != '0) w_next_y = r_frog_y - 1'b1;
        end else if (w_press[2]) begin
            if (r_frog_y != Y_LAST) w_next_y = r_frog_y + 1'b1;
        end else if (w_press[1]) begin
            if (w_drift_x != '0) w_next_x = w_drift_x - 1'b1;
        end else if (w_press[0]) begin
            if (w_drift_x != X_LAST) w_next_x = w_drift_x + 1'b1;
        end
    end

    always_ff @(posedge i_Clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_btn_prev <= '0;
            r_frog_x   <= X_SPAWN;
            r_frog_y   <= Y_SPAWN;
            r_score    <= '0;
            r_lives    <= LIVES_FULL;
        end else begin
            r_btn_prev <= w_btn;
            if (i_Restart) begin
                r_frog_x <= X_SPAWN;
                r_frog_y <= Y_SPAWN;
                r_score  <= '0;
                r_lives  <= LIVES_FULL;
            end else if (!w_game_over) begin
                if (i_Hazard) begin
                    // Drowned or run over
                    r_frog_x <= X_SPAWN;
                    r_frog_y <= Y_SPAWN;
                    r_lives  <= r_lives - 1'b1;
                end else if (w_at_goal) begin
                    r_frog_x <= X_SPAWN;
                    r_frog_y <= Y_SPAWN;
                    // Only a lily pad scores, bank just sends frog home
                    if (i_Tile == TILE_LILY) r_score <= r_score + 1'b1;
                end else begin
                    r_frog_x <= w_next_x;
                    r_frog_y <= w_next_y;
                end
            end
        end
    end

    assign o_Frog_X    = r_frog_x;
    assign o_Frog_Y    = r_frog_y;
    assign o_Score     = r_score;
    assign o_Lives     = r_lives;
    assign o_Game_Over = w_game_over;

endmodule

//--- rtl/frogger_game.sv
`timescale 1ns/10ps

module frogger_game #(
    parameter int START_LIVES = 3,
    parameter int LOG_LEN     = 5,
    parameter int CAR_LEN     = 2
) (
    input  logic                             i_Clk,
    input  logic                             i_rst_n,
    input  logic                             i_Up_Mvt,
    input  logic                             i_Down_Mvt,
    input  logic                             i_Left_Mvt,
    input  logic                             i_Right_Mvt,
    input  logic                             i_Cfg_Wr,
    input  logic [1:0]                       i_Cfg_Addr,
    input  logic [frogger_pkg::PERIOD_W-1:0] i_Cfg_Data,
    output logic [frogger_pkg::POS_W-1:0]    o_Frog_X,
    output logic [frogger_pkg::POS_W-1:0]    o_Frog_Y,
    output logic [6:0]                       o_Score,
    output logic [1:0]                       o_Lives,
    output logic                             o_Game_Over,
    output frogger_pkg::tile_t               o_Tile
);

    import frogger_pkg::*;

    // Config to playfield
    logic [PERIOD_W-1:0] w_log_period;
    logic [PERIOD_W-1:0] w_car_period;
    logic                w_scroll_en;
    // Restart goes to both playfield and frog
    logic                w_restart;
    // Playfield to frog
    logic                w_on_log;
    logic                w_hazard;
    logic                w_log_tick;

    game_cfg_regs game_cfg_regs_i (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_Cfg_Wr     (i_Cfg_Wr),
        .i_Cfg_Addr   (i_Cfg_Addr),
        .i_Cfg_Data   (i_Cfg_Data),
        .o_Log_Period (w_log_period),
        .o_Car_Period (w_car_period),
        .o_Scroll_En  (w_scroll_en),
        .o_Restart    (w_restart)
    );

    playfield_map #(
        .LOG_LEN (LOG_LEN),
        .CAR_LEN (CAR_LEN)
    ) playfield_map_i (
        .i_Clk        (i_Clk),
        .i_rst_n      (i_rst_n),
        .i_Log_Period (w_log_period),
        .i_Car_Period (w_car_period),
        .i_Scroll_En  (w_scroll_en),
        .i_Restart    (w_restart),
        .i_Frog_X     (o_Frog_X),
        .i_Frog_Y     (o_Frog_Y),
        .o_Tile       (o_Tile),
        .o_On_Log     (w_on_log),
        .o_Hazard     (w_hazard),
        .o_Log_Tick   (w_log_tick)
    );

    // Tile of frog's cell also reported outside
    frog_ctrl #(
        .START_LIVES (START_LIVES)
    ) frog_ctrl_i (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_Up_Mvt    (i_Up_Mvt),
        .i_Down_Mvt  (i_Down_Mvt),
        .i_Left_Mvt  (i_Left_Mvt),
        .i_Right_Mvt (i_Right_Mvt),
        .i_Tile      (o_Tile),
        .i_On_Log    (w_on_log),
        .i_Hazard    (w_hazard),
        .i_Log_Tick  (w_log_tick),
        .i_Restart   (w_restart),
        .o_Frog_X    (o_Frog_X),
        .o_Frog_Y    (o_Frog_Y),
        .o_Score     (o_Score),
        .o_Lives     (o_Lives),
        .o_Game_Over (o_Game_Over)
    );

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic o_Clk,
    output logic o_rst_n
);

    // Free running clock, starts low
    initial begin
        o_Clk = 1'b0;
        forever #(PERIOD_NS / 2) o_Clk = ~o_Clk;
    end

    // Reset held low, released just after a rising edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_Clk);
        #1 o_rst_n = 1'b1;
    end

endmodule

//--- tb/frogger_tb.sv
`timescale 1ns/10ps

module frogger_tb;

    import frogger_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int START_LIVES  = 3;
    localparam int LOG_LEN      = 5;
    localparam int CAR_LEN      = 2;

    // Button masks in up down left right order
    localparam int BTN_U = 8;
    localparam int BTN_D = 4;
    localparam int BTN_L = 2;
    localparam int BTN_R = 1;

    // Register addresses as table entries
    localparam int LOGP = int'(REG_LOG_PERIOD);
    localparam int CARP = int'(REG_CAR_PERIOD);
    localparam int CTRL = int'(REG_CTRL);

    // Optional config write, then reps of a press held for hold cycles and a release
    typedef struct packed {
        int rnd;
        int wr;
        int addr;
        int data;
        int btn;
        int hold;
        int reps;
    } stim_t;

    localparam int N_ROWS = 31;
    localparam stim_t STIM [N_ROWS] = '{
        // rnd wr addr data buttons hold reps
        '{0, 0, 0,    0, BTN_R,          1,  4},  // To column 13 with the last press clamped
        '{0, 0, 0,    0, BTN_L,          5,  1},  // Held left moves once
        '{0, 0, 0,    0, BTN_U | BTN_L,  1,  1},  // Up beats left
        '{0, 0, 0,    0, BTN_D,          1,  2},  // Back to row 14 then clamp
        '{0, 0, 0,    0, BTN_D | BTN_R,  1,  1},  // Down beats right
        '{0, 0, 0,    0, BTN_L | BTN_R,  1,  1},  // Left beats right
        '{1, 0, 0,    0, 0,              1, 40},  // Random left/right walk
        '{0, 1, CTRL, 2, 0,              0,  0},  // Restart
        '{0, 0, 0,    0, BTN_L,          1, 12},  // Clamp at column 0
        '{0, 0, 0,    0, BTN_R,          1, 10},
        '{0, 0, 0,    0, BTN_U,          1,  8},  // Drown at row 6 in column 10
        '{0, 0, 0,    0, BTN_U,          1,  7},  // Up to verge
        '{0, 0, 0,    0, BTN_L,          1,  9},  // Column 1
        '{0, 0, 0,    0, BTN_U,          1,  7},  // Logs to lily pad
        '{0, 0, 0,    0, BTN_U,          1,  7},
        '{0, 0, 0,    0, BTN_L,          1,  8},  // Column 2
        '{0, 0, 0,    0, BTN_U,          1,  7},  // Bank gives no score
        '{0, 1, LOGP, 4, 0,              0,  0},
        '{0, 0, 0,    0, BTN_U,          1,  7},
        '{0, 0, 0,    0, BTN_L,          1,  8},
        '{0, 0, 0,    0, BTN_U,          1,  1},  // Onto log at (2,6)
        '{0, 1, CTRL, 1, 0,              0,  0},  // Scroll on
        '{0, 0, 0,    0, 0,              7,  4},  // Drift left with wrap
        '{0, 1, CTRL, 0, 0,              0,  0},  // Scroll off
        '{0, 1, CARP, 1, 0,              0,  0},
        '{0, 1, CTRL, 3, 0,              0,  0},  // Restart with scroll on
        '{0, 0, 0,    0, BTN_U,         15,  3},  // Run over on row 13
        '{0, 0, 0,    0, BTN_U,          1,  2},  // Game over freezes the frog
        '{0, 0, 0,    0, BTN_L,          1,  2},
        '{0, 1, CTRL, 2, 0,              0,  0},  // Restart clears game over
        '{0, 0, 0,    0, BTN_U,          1,  1}
    };

    logic                i_Clk;
    logic                i_rst_n;
    logic                i_Up_Mvt;
    logic                i_Down_Mvt;
    logic                i_Left_Mvt;
    logic                i_Right_Mvt;
    logic                i_Cfg_Wr;
    logic [1:0]          i_Cfg_Addr;
    logic [PERIOD_W-1:0] i_Cfg_Data;
    logic [POS_W-1:0]    o_Frog_X;
    logic [POS_W-1:0]    o_Frog_Y;
    logic [6:0]          o_Score;
    logic [1:0]          o_Lives;
    logic                o_Game_Over;
    tile_t               o_Tile;

    // Reference model state
    int         m_x;
    int         m_y;
    int         m_score;
    int         m_lives;
    logic [3:0] m_prev_btn;
    int         m_log_per;
    int         m_car_per;
    bit         m_scroll;
    bit         m_restart;
    int         m_log_cnt;
    int         m_log_off;
    int         m_car_cnt;
    int         m_car_off;
    logic [15:0] lfsr_state;

    tb_clock_gen #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) tb_clock_gen_i (
        .o_Clk   (i_Clk),
        .o_rst_n (i_rst_n)
    );

    frogger_game #(
        .START_LIVES (START_LIVES),
        .LOG_LEN     (LOG_LEN),
        .CAR_LEN     (CAR_LEN)
    ) frogger_game_i (
        .i_Clk       (i_Clk),
        .i_rst_n     (i_rst_n),
        .i_Up_Mvt    (i_Up_Mvt),
        .i_Down_Mvt  (i_Down_Mvt),
        .i_Left_Mvt  (i_Left_Mvt),
        .i_Right_Mvt (i_Right_Mvt),
        .i_Cfg_Wr    (i_Cfg_Wr),
        .i_Cfg_Addr  (i_Cfg_Addr),
        .i_Cfg_Data  (i_Cfg_Data),
        .o_Frog_X    (o_Frog_X),
        .o_Frog_Y    (o_Frog_Y),
        .o_Score     (o_Score),
        .o_Lives     (o_Lives),
        .o_Game_Over (o_Game_Over),
        .o_Tile      (o_Tile)
    );

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic int row_cycles(input stim_t row);
        return ((row.wr != 0) ? 2 : 0) + row.reps * (row.hold + 1);
    endfunction

    // Tile of one cell from the band, lily and lane offset rules
    function automatic tile_t tile_at(input int x, input int y, input int log_off,
                                      input int car_off);
        bit log_here;
        bit car_here;
        // Logs drift left and cars drift right
        log_here = ((x + log_off) % GRID_COLS) < LOG_LEN;
        car_here = ((x - car_off + GRID_COLS) % GRID_COLS) < CAR_LEN;
        // Lily pads sit at every third column from 1
        if (y == 0) return (x % 3 == 1) ? TILE_LILY : TILE_GOAL_BANK;
        if (y >= 1 && y <= 6) return log_here ? TILE_LOG : TILE_WATER;
        if (y >= 8 && y <= 13) return car_here ? TILE_CAR : TILE_ROAD;
        return TILE_SAFE;
    endfunction

    task automatic check_val(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    // Advance the model by one rising edge with the inputs seen at that edge
    task automatic model_step();
        logic [3:0] btn;
        logic [3:0] pressed;
        tile_t      tile;
        bit         hazard;
        bit         tick;
        btn     = {i_Up_Mvt, i_Down_Mvt, i_Left_Mvt, i_Right_Mvt};
        pressed = btn & ~m_prev_btn;
        tile    = tile_at(m_x, m_y, m_log_off, m_car_off);
        // Open water or a car kills the frog
        hazard  = (tile == TILE_WATER) || (tile == TILE_CAR);
        tick    = m_scroll && !m_restart && (m_log_cnt == m_log_per - 1);
        if (m_restart) begin
            m_x     = SPAWN_X;
            m_y     = SPAWN_Y;
            m_score = 0;
            m_lives = START_LIVES;
        end else if (m_lives > 0) begin
            if (hazard) begin
                m_x     = SPAWN_X;
                m_y     = SPAWN_Y;
                m_lives = m_lives - 1;
            end else if (m_y == 0) begin
                if (tile == TILE_LILY) m_score = m_score + 1;
                m_x = SPAWN_X;
                m_y = SPAWN_Y;
            end else begin
                if (tick && tile == TILE_LOG) m_x = (m_x + GRID_COLS - 1) % GRID_COLS;
                if (pressed[3]) begin
                    if (m_y > 0) m_y = m_y - 1;
                end else if (pressed[2]) begin
                    if (m_y < GRID_ROWS - 1) m_y = m_y + 1;
                end else if (pressed[1]) begin
                    if (m_x > 0) m_x = m_x - 1;
                end else if (pressed[0]) begin
                    if (m_x < GRID_COLS - 1) m_x = m_x + 1;
                end
            end
        end
        m_prev_btn = btn;
        // Lane counters
        if (m_restart) begin
            m_log_cnt = 0;
            m_log_off = 0;
            m_car_cnt = 0;
            m_car_off = 0;
        end else if (m_scroll) begin
            if (m_log_cnt == m_log_per - 1) begin
                m_log_cnt = 0;
                m_log_off = (m_log_off + 1) % GRID_COLS;
            end else begin
                m_log_cnt = m_log_cnt + 1;
            end
            if (m_car_cnt == m_car_per - 1) begin
                m_car_cnt = 0;
                m_car_off = (m_car_off + 1) % GRID_COLS;
            end else begin
                m_car_cnt = m_car_cnt + 1;
            end
        end
        // Config registers with a restart that lasts one edge
        m_restart = 1'b0;
        if (i_Cfg_Wr) begin
            case (i_Cfg_Addr)
                REG_LOG_PERIOD: m_log_per = (i_Cfg_Data == '0) ? 1 : int'(i_Cfg_Data);
                REG_CAR_PERIOD: m_car_per = (i_Cfg_Data == '0) ? 1 : int'(i_Cfg_Data);
                REG_CTRL: begin
                    m_scroll  = i_Cfg_Data[0];
                    m_restart = i_Cfg_Data[1];
                end
                default: begin
                end
            endcase
        end
    endtask

    // Model steps at the edge and outputs are checked 1 ns later
    task automatic cycle();
        @(posedge i_Clk);
        model_step();
        #1;
        check_val("o_Frog_X", int'(o_Frog_X), m_x);
        check_val("o_Frog_Y", int'(o_Frog_Y), m_y);
        check_val("o_Score", int'(o_Score), m_score);
        check_val("o_Lives", int'(o_Lives), m_lives);
        check_val("o_Game_Over", int'(o_Game_Over), (m_lives == 0) ? 1 : 0);
        check_val("o_Tile", int'(o_Tile), int'(tile_at(m_x, m_y, m_log_off, m_car_off)));
    endtask

    task automatic run_row(input stim_t row);
        int         k;
        logic [3:0] dir;
        if (row.wr != 0) begin
            i_Cfg_Wr   = 1'b1;
            i_Cfg_Addr = 2'(row.addr);
            i_Cfg_Data = 16'(row.data);
            cycle();
            i_Cfg_Wr = 1'b0;
            cycle();
        end
        for (k = 0; k < row.reps; k++) begin
            dir = 4'(row.btn);
            // One LFSR bit picks left or right
            if (row.rnd != 0) begin
                dir        = lfsr_state[0] ? 4'(BTN_R) : 4'(BTN_L);
                lfsr_state = lfsr_next(lfsr_state);
            end
            {i_Up_Mvt, i_Down_Mvt, i_Left_Mvt, i_Right_Mvt} = dir;
            repeat (row.hold) cycle();
            {i_Up_Mvt, i_Down_Mvt, i_Left_Mvt, i_Right_Mvt} = 4'b0000;
            cycle();
        end
    endtask

    initial begin : stimulus
        int r;
        i_Up_Mvt    = 1'b0;
        i_Down_Mvt  = 1'b0;
        i_Left_Mvt  = 1'b0;
        i_Right_Mvt = 1'b0;
        i_Cfg_Wr    = 1'b0;
        i_Cfg_Addr  = 2'd0;
        i_Cfg_Data  = '0;
        // Model matches the reset state
        m_x        = SPAWN_X;
        m_y        = SPAWN_Y;
        m_score    = 0;
        m_lives    = START_LIVES;
        m_prev_btn = 4'b0000;
        m_log_per  = 1000;
        m_car_per  = 1000;
        m_scroll   = 1'b0;
        m_restart  = 1'b0;
        m_log_cnt  = 0;
        m_log_off  = 0;
        m_car_cnt  = 0;
        m_car_off  = 0;
        lfsr_state = 16'd64671;
        @(posedge i_rst_n);
        for (r = 0; r < N_ROWS; r++) begin
            run_row(STIM[r]);
        end
        $display("All tests passed");
        $finish;
    end

    // Limit from the longest row of the table
    initial begin : watchdog
        int r;
        int longest;
        int limit_ns;
        longest = 1;
        for (r = 0; r < N_ROWS; r++) begin
            if (row_cycles(STIM[r]) > longest) longest = row_cycles(STIM[r]);
        end
        limit_ns = (N_ROWS * longest + RESET_CYCLES + 100) * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("Some tests failed");
        $fatal(1);
    end

endmodule

//--- files.f
rtl/frogger_pkg.sv
rtl/game_cfg_regs.sv
rtl/playfield_map.sv
rtl/frog_ctrl.sv
rtl/frogger_game.sv
tb/tb_clock_gen.sv
tb/frogger_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := frogger_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --timescale 1ns/10ps --top-module $(TOP) --Mdir $(OBJ_DIR)

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
